/* design/mipsPkg.sv */
`default_nettype none

package mipsPkg;

    // Primary opcode field, inst[31:26]
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddi  = 6'h08,
        opSlti  = 6'h0a,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeE;

    // R-type function field, inst[5:0]
    typedef enum logic [5:0] {
        fnJr  = 6'h08,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } funcE;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpE;

    // Writeback source
    typedef enum logic [1:0] {
        wbAlu,
        wbMem,
        wbLink
    } wbSelE;

    // Destination register; dstRa is r31 for jal
    typedef enum logic [1:0] {
        dstRt,
        dstRd,
        dstRa
    } regDstE;

    typedef enum logic [1:0] {
        fwdReg,
        fwdMem,
        fwdWb
    } fwdSelE;

    localparam logic [31:0] defaultResetPc = 32'h0000_0000;

endpackage

`default_nettype wire

/* design/pipeIfs.sv */
`timescale 1ns/1ps
`default_nettype none

// ID/EX pipeline register contents
interface idExIf;
    import mipsPkg::*;

    aluOpE       aluOp;
    logic        aluSrc;
    regDstE      regDst;
    wbSelE       wbSel;
    logic        memRead;
    logic        memWrite;
    logic        regWrite;
    logic [31:0] readData1;
    logic [31:0] readData2;
    logic [31:0] immediate;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] linkPc;

    modport producer (
        output aluOp, aluSrc, regDst, wbSel, memRead, memWrite, regWrite,
        output readData1, readData2, immediate, rs, rt, rd, linkPc
    );

    modport consumer (
        input aluOp, aluSrc, regDst, wbSel, memRead, memWrite, regWrite,
        input readData1, readData2, immediate, rs, rt, rd, linkPc
    );
endinterface

// EX/MEM pipeline register contents
interface exMemIf;
    import mipsPkg::*;

    logic        memRead;
    logic        memWrite;
    logic        regWrite;
    wbSelE       wbSel;
    logic [4:0]  rd;
    logic [31:0] aluRes;
    logic [31:0] storeData;
    logic [31:0] linkPc;

    modport producer (
        output memRead, memWrite, regWrite, wbSel, rd, aluRes, storeData, linkPc
    );

    modport consumer (input regWrite, wbSel, rd, aluRes, linkPc);

    // Hazard unit only looks at pending writes
    modport observer (input regWrite, rd);
endinterface

`default_nettype wire

/* design/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
    parameter logic [31:0] resetPc = mipsPkg::defaultResetPc
) (
    input  wire         clk,
    input  wire         rstN,
    input  wire  [31:0] instData,
    input  wire         redirect,
    input  wire  [31:0] redirectPc,
    input  wire         stall,
    input  wire         flush,
    output logic [31:0] instAddr,
    output logic [31:0] pcPlus4,
    output logic [31:0] inst
);

    logic [31:0] pc;
    logic [31:0] pcInc;
    logic [31:0] nextPc;

    assign pcInc    = pc + 32'd4;
    assign nextPc   = redirect ? redirectPc : pcInc;
    assign instAddr = pc;

    // PC and the fetched word; a zero word decodes as a bubble
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc   <= resetPc;
            inst <= '0;
        end else if (!stall) begin
            pc <= nextPc;
            if (flush) begin
                inst <= '0;
            end else begin
                inst <= instData;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pcPlus4 <= pcInc;
        end
    end

endmodule

`default_nettype wire

/* design/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  wire         clk,
    input  wire         rstN,
    input  wire  [31:0] pcPlus4,
    input  wire  [31:0] inst,
    input  wire         wbRegWrite,
    input  wire  [4:0]  wbRd,
    input  wire  [31:0] wbData,
    exMemIf.observer    exMem,
    idExIf.producer     idEx,
    output logic        redirect,
    output logic [31:0] redirectPc,
    output logic        stall,
    output logic        flush
);
    import mipsPkg::*;

    opcodeE      opcode;
    funcE        funct;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic [31:0] regFile [32];
    logic [31:0] readData1;
    logic [31:0] readData2;

    aluOpE       aluOp;
    regDstE      regDst;
    wbSelE       wbSel;
    logic        aluSrc, memRead, memWrite, regWrite;
    logic        isBeq, isBne, isJump, isJr, useRs, useRt;

    logic [4:0]  exDest;
    logic        loadUse, branchStall, takeBranch;
    logic        exHitRs, exHitRt, memHitRs, memHitRt;

    assign opcode = opcodeE'(inst[31:26]);
    assign funct  = funcE'(inst[5:0]);
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign imm    = {{16{inst[15]}}, inst[15:0]};

    // Register file, r0 never written
    always_ff @(posedge clk) begin
        if (wbRegWrite && wbRd != 5'd0) begin
            regFile[wbRd] <= wbData;
        end
    end

    // Write-through so WB results reach decode in the same cycle
    assign readData1 = (rs == 5'd0) ? 32'd0 :
                       (wbRegWrite && wbRd == rs) ? wbData : regFile[rs];
    assign readData2 = (rt == 5'd0) ? 32'd0 :
                       (wbRegWrite && wbRd == rt) ? wbData : regFile[rt];

    always_comb begin
        aluOp    = aluAdd;
        aluSrc   = 1'b0;
        regDst   = dstRt;
        wbSel    = wbAlu;
        memRead  = 1'b0;
        memWrite = 1'b0;
        regWrite = 1'b0;
        isBeq    = 1'b0;
        isBne    = 1'b0;
        isJump   = 1'b0;
        isJr     = 1'b0;
        case (opcode)
            opRType: begin
                regDst = dstRd;
                case (funct)
                    fnAdd:   begin regWrite = 1'b1; aluOp = aluAdd; end
                    fnSub:   begin regWrite = 1'b1; aluOp = aluSub; end
                    fnAnd:   begin regWrite = 1'b1; aluOp = aluAnd; end
                    fnOr:    begin regWrite = 1'b1; aluOp = aluOr;  end
                    fnSlt:   begin regWrite = 1'b1; aluOp = aluSlt; end
                    fnJr:    isJr = 1'b1;
                    default: ;
                endcase
            end
            opAddi:  begin aluSrc = 1'b1; regWrite = 1'b1; end
            opSlti:  begin aluSrc = 1'b1; regWrite = 1'b1; aluOp = aluSlt; end
            opLw:    begin aluSrc = 1'b1; regWrite = 1'b1; memRead = 1'b1; wbSel = wbMem; end
            opSw:    begin aluSrc = 1'b1; memWrite = 1'b1; end
            opBeq:   isBeq = 1'b1;
            opBne:   isBne = 1'b1;
            opJ:     isJump = 1'b1;
            opJal:   begin isJump = 1'b1; regWrite = 1'b1; regDst = dstRa; wbSel = wbLink; end
            default: ;
        endcase
    end

    // Which source fields are real operands
    assign useRs = !isJump;
    assign useRt = (opcode == opRType) || isBeq || isBne || memWrite;

    always_comb begin
        case (idEx.regDst)
            dstRt:   exDest = idEx.rt;
            dstRd:   exDest = idEx.rd;
            default: exDest = 5'd31;
        endcase
    end

    assign loadUse = idEx.memRead && exDest != 5'd0 &&
                     ((useRs && exDest == rs) || (useRt && exDest == rt));

    // Compares in decode see only the register file, so wait out EX and MEM writers
    assign exHitRs  = idEx.regWrite && exDest != 5'd0 && exDest == rs;
    assign exHitRt  = idEx.regWrite && exDest != 5'd0 && exDest == rt;
    assign memHitRs = exMem.regWrite && exMem.rd != 5'd0 && exMem.rd == rs;
    assign memHitRt = exMem.regWrite && exMem.rd != 5'd0 && exMem.rd == rt;
    assign branchStall = ((isBeq || isBne || isJr) && (exHitRs || memHitRs)) ||
                         ((isBeq || isBne) && (exHitRt || memHitRt));

    assign stall = loadUse || branchStall;

    assign takeBranch = (isBeq && readData1 == readData2) ||
                        (isBne && readData1 != readData2);
    assign redirect   = !stall && (takeBranch || isJump || isJr);
    assign flush      = redirect;

    always_comb begin
        if (isJr) begin
            redirectPc = readData1;
        end else if (isJump) begin
            redirectPc = {pcPlus4[31:28], inst[25:0], 2'b00};
        end else begin
            redirectPc = pcPlus4 + {imm[29:0], 2'b00};
        end
    end

    // ID/EX control, bubble on stall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx.memRead  <= 1'b0;
            idEx.memWrite <= 1'b0;
            idEx.regWrite <= 1'b0;
        end else begin
            idEx.memRead  <= memRead && !stall;
            idEx.memWrite <= memWrite && !stall;
            idEx.regWrite <= regWrite && !stall;
        end
    end

    always_ff @(posedge clk) begin
        idEx.aluOp     <= aluOp;
        idEx.aluSrc    <= aluSrc;
        idEx.regDst    <= regDst;
        idEx.wbSel     <= wbSel;
        idEx.readData1 <= readData1;
        idEx.readData2 <= readData2;
        idEx.immediate <= imm;
        idEx.rs        <= rs;
        idEx.rt        <= rt;
        idEx.rd        <= rd;
        idEx.linkPc    <= pcPlus4;
    end

endmodule

`default_nettype wire

/* design/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input wire        clk,
    input wire        rstN,
    input wire        wbRegWrite,
    input wire [4:0]  wbRd,
    input wire [31:0] wbData,
    idExIf.consumer   idEx,
    exMemIf.producer  exMem
);
    import mipsPkg::*;

    fwdSelE      fwdA;
    fwdSelE      fwdB;
    logic [31:0] memFwdData;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluB;
    logic [31:0] aluRes;
    logic [4:0]  destReg;

    // Nearest producer wins
    function automatic fwdSelE pickSource(
        input logic [4:0] src,
        input logic       memWr,
        input logic [4:0] memDst,
        input logic       wbWr,
        input logic [4:0] wbDst
    );
        if (src == 5'd0) return fwdReg;
        if (memWr && memDst == src) return fwdMem;
        if (wbWr && wbDst == src) return fwdWb;
        return fwdReg;
    endfunction

    function automatic logic [31:0] selectOperand(
        input fwdSelE      sel,
        input logic [31:0] regVal,
        input logic [31:0] memVal,
        input logic [31:0] wbVal
    );
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign fwdA = pickSource(idEx.rs, exMem.regWrite, exMem.rd, wbRegWrite, wbRd);
    assign fwdB = pickSource(idEx.rt, exMem.regWrite, exMem.rd, wbRegWrite, wbRd);

    // A jal in MEM carries its link address, not an ALU result
    assign memFwdData = (exMem.wbSel == wbLink) ? exMem.linkPc : exMem.aluRes;

    assign opA  = selectOperand(fwdA, idEx.readData1, memFwdData, wbData);
    assign opB  = selectOperand(fwdB, idEx.readData2, memFwdData, wbData);
    assign aluB = idEx.aluSrc ? idEx.immediate : opB;

    always_comb begin
        case (idEx.aluOp)
            aluSub:  aluRes = opA - aluB;
            aluAnd:  aluRes = opA & aluB;
            aluOr:   aluRes = opA | aluB;
            aluSlt:  aluRes = {31'd0, $signed(opA) < $signed(aluB)};
            default: aluRes = opA + aluB;
        endcase
    end

    always_comb begin
        case (idEx.regDst)
            dstRt:   destReg = idEx.rt;
            dstRd:   destReg = idEx.rd;
            default: destReg = 5'd31;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMem.memRead  <= 1'b0;
            exMem.memWrite <= 1'b0;
            exMem.regWrite <= 1'b0;
        end else begin
            exMem.memRead  <= idEx.memRead;
            exMem.memWrite <= idEx.memWrite;
            exMem.regWrite <= idEx.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        exMem.wbSel     <= idEx.wbSel;
        exMem.rd        <= destReg;
        exMem.aluRes    <= aluRes;
        exMem.storeData <= opB;
        exMem.linkPc    <= idEx.linkPc;
    end

endmodule

`default_nettype wire

/* design/memWbStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memWbStage (
    input  wire         clk,
    input  wire         rstN,
    input  wire  [31:0] memReadData,
    exMemIf.consumer    exMem,
    output logic        wbRegWrite,
    output logic [4:0]  wbRd,
    output logic [31:0] wbData
);
    import mipsPkg::*;

    wbSelE       wbSel;
    logic [31:0] memData;
    logic [31:0] aluRes;
    logic [31:0] linkPc;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbRegWrite <= 1'b0;
        end else begin
            wbRegWrite <= exMem.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        wbSel   <= exMem.wbSel;
        wbRd    <= exMem.rd;
        memData <= memReadData;
        aluRes  <= exMem.aluRes;
        linkPc  <= exMem.linkPc;
    end

    always_comb begin
        case (wbSel)
            wbMem:   wbData = memData;
            wbLink:  wbData = linkPc;
            default: wbData = aluRes;
        endcase
    end

endmodule

`default_nettype wire

/* design/mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore #(
    parameter logic [31:0] resetPc = mipsPkg::defaultResetPc
) (
    input  wire         clk,
    input  wire         rstN,
    input  wire  [31:0] instData,
    input  wire  [31:0] memReadData,
    output logic [31:0] instAddr,
    output logic [31:0] memAddr,
    output logic [31:0] memWriteData,
    output logic        memRead,
    output logic        memWrite
);

    logic [31:0] pcPlus4;
    logic [31:0] inst;
    logic        redirect;
    logic [31:0] redirectPc;
    logic        stall;
    logic        flush;
    logic        wbRegWrite;
    logic [4:0]  wbRd;
    logic [31:0] wbData;

    idExIf  idEx ();
    exMemIf exMem ();

    fetchStage #(
        .resetPc(resetPc)
    ) fetch (
        .clk        (clk),
        .rstN       (rstN),
        .instData   (instData),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .stall      (stall),
        .flush      (flush),
        .instAddr   (instAddr),
        .pcPlus4    (pcPlus4),
        .inst       (inst)
    );

    decodeStage decode (
        .clk        (clk),
        .rstN       (rstN),
        .pcPlus4    (pcPlus4),
        .inst       (inst),
        .wbRegWrite (wbRegWrite),
        .wbRd       (wbRd),
        .wbData     (wbData),
        .exMem      (exMem),
        .idEx       (idEx),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .stall      (stall),
        .flush      (flush)
    );

    executeStage execute (
        .clk        (clk),
        .rstN       (rstN),
        .wbRegWrite (wbRegWrite),
        .wbRd       (wbRd),
        .wbData     (wbData),
        .idEx       (idEx),
        .exMem      (exMem)
    );

    memWbStage memWb (
        .clk         (clk),
        .rstN        (rstN),
        .memReadData (memReadData),
        .exMem       (exMem),
        .wbRegWrite  (wbRegWrite),
        .wbRd        (wbRd),
        .wbData      (wbData)
    );

    // Data memory port straight from EX/MEM
    assign memAddr      = exMem.aluRes;
    assign memWriteData = exMem.storeData;
    assign memRead      = exMem.memRead;
    assign memWrite     = exMem.memWrite;

endmodule

`default_nettype wire

/* dv/storeChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module storeChecker (
    input  wire        clk,
    input  wire        rstN,
    input  wire        memWrite,
    input  wire [31:0] memAddr,
    input  wire [31:0] memWriteData,
    output int         passCount,
    output int         failCount,
    output int         doneCount
);

    localparam logic [31:0] endAddr = 32'h0000_03fc;

    logic [31:0] expAddrQ [$];
    logic [31:0] expDataQ [$];
    string       testName;
    int          problems;
    int          matched;

    task automatic beginTest(input string name);
        testName = name;
        expAddrQ.delete();
        expDataQ.delete();
        problems = 0;
        matched  = 0;
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        expAddrQ.push_back(addr);
        expDataQ.push_back(data);
    endtask

    task automatic finishTest();
        if (problems == 0) begin
            passCount++;
            $display("%s: pass, %0d stores matched", testName, matched);
        end else begin
            failCount++;
            $display("%s: fail, %0d problems", testName, problems);
        end
        doneCount++;
    endtask

    // Mid-cycle sample, one write per cycle
    always @(negedge clk) begin : compareStores
        logic [31:0] expAddr;
        logic [31:0] expData;
        if (rstN && memWrite) begin
            if (expAddrQ.size() == 0) begin
                $display("%s: extra store to address 0x%08h that the program never makes",
                         testName, memAddr);
                problems++;
            end else begin
                expAddr = expAddrQ.pop_front();
                expData = expDataQ.pop_front();
                if (expAddr !== memAddr || expData !== memWriteData) begin
                    $display("error %s: expected addr 0x%08h data 0x%08h, actual addr 0x%08h data 0x%08h",
                             testName, expAddr, expData, memAddr, memWriteData);
                    problems++;
                end else begin
                    matched++;
                end
            end
            if (memAddr == endAddr) begin
                if (expAddrQ.size() != 0) begin
                    $display("%s: %0d expected stores never appeared before the end store",
                             testName, expAddrQ.size());
                    problems++;
                end
                finishTest();
            end
        end
    end

endmodule

`default_nettype wire

/* dv/mipsCoreAsserts.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCoreAsserts (
    input wire        clk,
    input wire        rstN,
    input wire        memRead,
    input wire        memWrite,
    input wire [31:0] instAddr,
    input wire        stall
);

    int failures;

    noReadAndWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(memRead && memWrite))
        else begin
            $error("memRead and memWrite are high in the same cycle");
            failures++;
        end

    // First sample after power-up has no settled past value
    quietInReset: assert property (@(posedge clk)
        (!rstN && !$past(rstN)) |-> (!memRead && !memWrite))
        else begin
            $error("data memory access while reset is asserted");
            failures++;
        end

    alignedFetch: assert property (@(posedge clk) disable iff (!rstN)
        instAddr[1:0] == 2'b00)
        else begin
            $error("instAddr is not word aligned");
            failures++;
        end

    pcHoldsOnStall: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> $stable(instAddr))
        else begin
            $error("instAddr moved in the cycle after a stall");
            failures++;
        end

endmodule

`default_nettype wire

/* dv/mipsCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;
    import mipsPkg::*;

    localparam int numTests  = 5;
    localparam int clkPeriod = 40;

    logic        clk;
    logic        rstN;
    logic [31:0] instData;
    logic [31:0] memReadData;
    logic [31:0] instAddr;
    logic [31:0] memAddr;
    logic [31:0] memWriteData;
    logic        memRead;
    logic        memWrite;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] expAddrQ [$];
    logic [31:0] expDataQ [$];
    int          progLen;
    int          testCount;
    int          passCount;
    int          failCount;
    int          doneCount;

    mipsCore uut (
        .clk          (clk),
        .rstN         (rstN),
        .instData     (instData),
        .memReadData  (memReadData),
        .instAddr     (instAddr),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memRead      (memRead),
        .memWrite     (memWrite)
    );

    storeChecker storeCheck (
        .clk          (clk),
        .rstN         (rstN),
        .memWrite     (memWrite),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .passCount    (passCount),
        .failCount    (failCount),
        .doneCount    (doneCount)
    );

    bind mipsCore mipsCoreAsserts coreChecks (
        .clk      (clk),
        .rstN     (rstN),
        .memRead  (memRead),
        .memWrite (memWrite),
        .instAddr (instAddr),
        .stall    (stall)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Both memories read combinationally, word addressed
    assign instData    = imem[instAddr[9:2]];
    // Junk word unless the core asks for a read
    assign memReadData = memRead ? dmem[memAddr[9:2]] : 32'hbad0_bad0;

    always @(posedge clk) begin
        if (memWrite) begin
            dmem[memAddr[9:2]] <= memWriteData;
        end
    end

    function automatic logic [31:0] encodeR(funcE fn, int rd, int rs, int rt);
        return {opRType, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeI(opcodeE op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] encodeJ(opcodeE op, int target);
        return {op, 26'(target >> 2)};
    endfunction

    // ISA-level model, one instruction per step, no pipeline
    function automatic void predictStores();
        logic [31:0] regs [32];
        logic [31:0] mem [256];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] nextPc;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic        done;
        int          steps;
        expAddrQ.delete();
        expDataQ.delete();
        for (int i = 0; i < 256; i++) begin
            mem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'd0;
        end
        pc    = defaultResetPc;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 2000) begin
            ins    = imem[pc[9:2]];
            a      = regs[ins[25:21]];
            b      = regs[ins[20:16]];
            rt     = ins[20:16];
            rd     = ins[15:11];
            imm    = {{16{ins[15]}}, ins[15:0]};
            addr   = a + imm;
            nextPc = pc + 32'd4;
            case (ins[31:26])
                opRType: begin
                    case (ins[5:0])
                        fnAdd: regs[rd] = a + b;
                        fnSub: regs[rd] = a - b;
                        fnAnd: regs[rd] = a & b;
                        fnOr:  regs[rd] = a | b;
                        fnSlt: regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        fnJr:  nextPc = a;
                        default: ;
                    endcase
                end
                opAddi: regs[rt] = a + imm;
                opSlti: regs[rt] = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
                opLw:   regs[rt] = mem[addr[9:2]];
                opSw: begin
                    mem[addr[9:2]] = b;
                    expAddrQ.push_back(addr);
                    expDataQ.push_back(b);
                    done = (addr == 32'h0000_03fc);
                end
                opBeq: begin
                    if (a == b) nextPc = pc + 32'd4 + (imm << 2);
                end
                opBne: begin
                    if (a != b) nextPc = pc + 32'd4 + (imm << 2);
                end
                opJ: nextPc = {nextPc[31:28], ins[25:0], 2'b00};
                opJal: begin
                    regs[31] = pc + 32'd4;
                    nextPc   = {nextPc[31:28], ins[25:0], 2'b00};
                end
                default: ;
            endcase
            regs[0] = 32'd0;
            pc      = nextPc;
            steps++;
        end
    endfunction

    task automatic fillMemories();
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'd0;
            dmem[i] = (i * 32'h0101_0101) ^ {testCount[7:0], 24'h00a55a};
        end
    endtask

    task automatic emit(input logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    // Hold the core in reset while the next program is loaded
    task automatic startProgram();
        @(posedge clk);
        rstN <= 1'b0;
        fillMemories();
        progLen = 0;
    endtask

    task automatic endProgram();
        emit(encodeI(opSw, 1, 0, 32'h3fc));
        emit(encodeJ(opJ, progLen * 4));
    endtask

    task automatic runProgram(input string name);
        predictStores();
        storeCheck.beginTest(name);
        foreach (expAddrQ[i]) begin
            storeCheck.expectStore(expAddrQ[i], expDataQ[i]);
        end
        testCount++;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        wait (doneCount == testCount);
    endtask

    task automatic aluChainTest();
        startProgram();
        emit(encodeI(opAddi, 1, 0, 5));
        emit(encodeI(opAddi, 2, 0, -3));
        emit(encodeR(fnAdd, 3, 1, 2));
        emit(encodeR(fnSub, 4, 3, 1));
        emit(encodeR(fnAnd, 5, 4, 2));
        emit(encodeR(fnOr, 6, 5, 3));
        emit(encodeR(fnSlt, 7, 2, 1));
        emit(encodeI(opSlti, 8, 4, -1));
        emit(encodeI(opAddi, 9, 7, 100));
        emit(encodeR(fnAdd, 10, 9, 1));
        emit(encodeI(opSw, 10, 0, 28));
        for (int r = 3; r < 10; r++) begin
            emit(encodeI(opSw, r, 0, (r - 3) * 4));
        end
        endProgram();
        runProgram("aluChain");
    endtask

    task automatic loadUseTest();
        startProgram();
        emit(encodeI(opAddi, 1, 0, 8));
        emit(encodeI(opLw, 2, 1, 0));
        emit(encodeR(fnAdd, 3, 2, 2));
        emit(encodeI(opSw, 3, 0, 32));
        emit(encodeI(opLw, 4, 1, 4));
        emit(encodeI(opSw, 4, 0, 36));
        emit(encodeI(opLw, 5, 0, 12));
        emit(encodeI(opAddi, 6, 5, 1));
        emit(encodeI(opSw, 6, 1, 0));
        // Reads back the word stored just before
        emit(encodeI(opLw, 7, 0, 8));
        emit(encodeI(opSw, 7, 0, 40));
        endProgram();
        runProgram("loadUse");
    endtask

    task automatic branchTest();
        startProgram();
        emit(encodeI(opAddi, 1, 0, 7));
        emit(encodeI(opAddi, 2, 0, 7));
        emit(encodeI(opBeq, 2, 1, 1));
        emit(encodeI(opSw, 1, 0, 0));
        emit(encodeI(opAddi, 3, 0, 9));
        emit(encodeI(opBne, 3, 1, 1));
        emit(encodeI(opSw, 3, 0, 4));
        emit(encodeI(opBeq, 3, 1, 1));
        emit(encodeI(opSw, 3, 0, 8));
        emit(encodeI(opBne, 2, 1, 1));
        emit(encodeI(opSw, 2, 0, 12));
        emit(encodeI(opLw, 4, 0, 16));
        emit(encodeI(opBeq, 4, 4, 1));
        emit(encodeI(opSw, 4, 0, 20));
        emit(encodeI(opSw, 4, 0, 24));
        endProgram();
        runProgram("branches");
    endtask

    task automatic jumpTest();
        startProgram();
        emit(encodeI(opAddi, 1, 0, 3));
        emit(encodeJ(opJal, 5 * 4));
        emit(encodeI(opSw, 31, 0, 0));
        emit(encodeJ(opJ, 8 * 4));
        emit(encodeI(opSw, 1, 0, 4));
        // Subroutine
        emit(encodeI(opAddi, 1, 1, 10));
        emit(encodeR(fnJr, 0, 31, 0));
        emit(encodeI(opSw, 1, 0, 12));
        emit(encodeI(opSw, 1, 0, 16));
        endProgram();
        runProgram("jumps");
    endtask

    task automatic randomTest();
        int r;
        int kind;
        int rd;
        int rs;
        int rt;
        startProgram();
        for (r = 1; r < 16; r++) begin
            emit(encodeI(opAddi, r, 0, $urandom));
        end
        repeat (60) begin
            kind = $urandom % 9;
            rd   = 1 + $urandom % 15;
            rs   = $urandom % 16;
            rt   = $urandom % 16;
            case (kind)
                0: emit(encodeR(fnAdd, rd, rs, rt));
                1: emit(encodeR(fnSub, rd, rs, rt));
                2: emit(encodeR(fnAnd, rd, rs, rt));
                3: emit(encodeR(fnOr, rd, rs, rt));
                4: emit(encodeR(fnSlt, rd, rs, rt));
                5: emit(encodeI(opAddi, rd, rs, $urandom));
                6: emit(encodeI(opSlti, rd, rs, $urandom));
                7: emit(encodeI(opLw, rd, 0, 4 * ($urandom % 255)));
                default: emit(encodeI(opSw, rt, 0, 4 * ($urandom % 255)));
            endcase
        end
        endProgram();
        runProgram("randomMix");
    endtask

    initial begin
        void'($urandom(61));
        rstN      = 1'b0;
        testCount = 0;
        progLen   = 0;
        fillMemories();
        aluChainTest();
        loadUseTest();
        branchTest();
        jumpTest();
        randomTest();
        $display("summary: %0d passed, %0d failed, %0d assertion failures",
                 passCount, failCount, uut.coreChecks.failures);
        if (passCount == numTests && failCount == 0 && uut.coreChecks.failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Budget of 400 cycles per test
    initial begin
        #(numTests * 400 * clkPeriod);
        $display("timeout: the tests did not finish within %0d clock cycles", numTests * 400);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
design/mipsPkg.sv
design/pipeIfs.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memWbStage.sv
design/mipsCore.sv
dv/storeChecker.sv
dv/mipsCoreAsserts.sv
dv/mipsCoreTb.sv

/* Bender.yml */
package:
  name: mipsCore

sources:
  - design/mipsPkg.sv
  - design/pipeIfs.sv
  - design/fetchStage.sv
  - design/decodeStage.sv
  - design/executeStage.sv
  - design/memWbStage.sv
  - design/mipsCore.sv
  - target: test
    files:
      - dv/storeChecker.sv
      - dv/mipsCoreAsserts.sv
      - dv/mipsCoreTb.sv
